// File: Makefile
# Verilator build for the scheduler testbench

TOP := SchedulerTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: common/BasicTypes.sv
// ################################################
// Machine-width types shared by every scheduler block:
// physical tags, op payload and per-class issue widths.
// Referenced by scoped name from the other files.
// ################################################

package BasicTypes;

    // Physical register file
    localparam int PHYS_REG_NUM = 32;
    localparam int PHYS_TAG_WIDTH = $clog2(PHYS_REG_NUM);
    typedef logic [PHYS_TAG_WIDTH-1:0] PhysTagPath;

    // Opaque op payload, carried unchanged to issue
    localparam int PAYLOAD_WIDTH = 16;
    typedef logic [PAYLOAD_WIDTH-1:0] PayloadPath;

    // Source operands per op
    localparam int SRC_OPERAND_NUM = 2;

    // Issue ports per class; integer ports come first
    localparam int INT_ISSUE_WIDTH = 2;
    localparam int MEM_ISSUE_WIDTH = 1;
    localparam int ISSUE_WIDTH = INT_ISSUE_WIDTH + MEM_ISSUE_WIDTH;

endpackage : BasicTypes

// File: common/SchedulerTypes.sv
// ################################################
// Scheduler structures: the dispatched op (Wishbone
// write data), queue entry, issue slot and the wakeup
// broadcast sent once per issue port.
// ################################################

package SchedulerTypes;

    typedef enum logic {
        OP_INT = 1'b0,
        OP_MEM = 1'b1
    } OpClass;

    // Dispatch word on datIn
    typedef struct packed {
        OpClass opClass;
        BasicTypes::PhysTagPath dstTag;
        logic [BasicTypes::SRC_OPERAND_NUM-1:0] srcValid;
        BasicTypes::PhysTagPath [BasicTypes::SRC_OPERAND_NUM-1:0] srcTag;
        BasicTypes::PayloadPath payload;
    } DispatchOp;

    // One issue queue slot; srcReady is set for unused sources
    typedef struct packed {
        logic valid;
        OpClass opClass;
        BasicTypes::PhysTagPath dstTag;
        logic [BasicTypes::SRC_OPERAND_NUM-1:0] srcReady;
        BasicTypes::PhysTagPath [BasicTypes::SRC_OPERAND_NUM-1:0] srcTag;
        BasicTypes::PayloadPath payload;
    } IssueQueueEntry;

    typedef struct packed {
        logic valid;
        BasicTypes::PhysTagPath dstTag;
        BasicTypes::PayloadPath payload;
    } IssueSlot;

    typedef struct packed {
        logic valid;
        BasicTypes::PhysTagPath dstTag;
    } WakeupBroadcast;

endpackage : SchedulerTypes

// File: flist.f
common/BasicTypes.sv
common/SchedulerTypes.sv
scheduler/Picker.sv
scheduler/SelectLogic.sv
scheduler/WakeupLogic.sv
scheduler/IssueQueue.sv
source/SchedulerTop.sv
verif/SchedulerTb.sv

// File: scheduler/IssueQueue.sv
// ################################################
// Issue queue storage. Accepts ops over a Wishbone
// classic write slave, tracks source readiness from
// issue broadcasts, frees granted entries and empties
// on flush.
// ################################################

`timescale 1ns/10ps

module IssueQueue #(
    parameter int ENTRY_NUM = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  SchedulerTypes::DispatchOp datIn,
    output logic ack,
    input  SchedulerTypes::WakeupBroadcast broadcast [BasicTypes::ISSUE_WIDTH],
    input  logic [ENTRY_NUM-1:0] grantVector,
    output SchedulerTypes::IssueQueueEntry entry [ENTRY_NUM],
    output logic claimValid,
    output BasicTypes::PhysTagPath claimTag,
    output BasicTypes::PhysTagPath [BasicTypes::SRC_OPERAND_NUM-1:0] lookupTag,
    input  logic [BasicTypes::SRC_OPERAND_NUM-1:0] lookupReady
);

    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM);
    localparam int PORT_NUM = BasicTypes::ISSUE_WIDTH;
    localparam int SRC_NUM = BasicTypes::SRC_OPERAND_NUM;

    SchedulerTypes::IssueQueueEntry entryReg [ENTRY_NUM];
    SchedulerTypes::IssueQueueEntry newEntry;
    logic [ENTRY_NUM-1:0] valid;
    logic [INDEX_WIDTH-1:0] allocPtr;
    logic hasFree;
    logic queueFull;
    logic request;

    assign request = cyc && stb && we;

    // Lowest free slot receives the next dispatch
    always_comb begin
        allocPtr = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            valid[i] = entryReg[i].valid;
            if (!entryReg[i].valid) begin
                allocPtr = INDEX_WIDTH'(i);
            end
        end
        hasFree = !(&valid);
        queueFull = &valid;
    end

    // Registered ack, one cycle per request
    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= request && !ack && hasFree;
        end
    end

    // Datin is held through the ack cycle, so look up then
    assign lookupTag = datIn.srcTag;
    assign claimValid = ack;
    assign claimTag = datIn.dstTag;

    always_comb begin
        newEntry.valid = 1'b1;
        newEntry.opClass = datIn.opClass;
        newEntry.dstTag = datIn.dstTag;
        newEntry.srcReady = ~datIn.srcValid | lookupReady;
        newEntry.srcTag = datIn.srcTag;
        newEntry.payload = datIn.payload;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRY_NUM; i++) begin
                entryReg[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < ENTRY_NUM; i++) begin
                if (flush || grantVector[i]) begin
                    entryReg[i].valid <= 1'b0;
                end
                for (int s = 0; s < SRC_NUM; s++) begin
                    for (int p = 0; p < PORT_NUM; p++) begin
                        if (broadcast[p].valid &&
                            (broadcast[p].dstTag == entryReg[i].srcTag[s])) begin
                            entryReg[i].srcReady[s] <= 1'b1;
                        end
                    end
                end
            end
            // An op acked during a flush still lands
            if (ack) begin
                entryReg[allocPtr] <= newEntry;
            end
        end
    end

    assign entry = entryReg;

    // The slot written on the ack edge must still be free
    AckNotWhenFull: assert property (@(posedge clk) disable iff (reset)
        ack |-> !queueFull)
    else $error("IssueQueue acked while every entry was valid");

endmodule : IssueQueue

// File: scheduler/Picker.sv
// ################################################
// Fixed-priority picker. Grants up to GRANT_NUM of
// the request bits, lowest index first, and reports
// the one-hot grant mask plus an index per grant.
// ################################################

`timescale 1ns/10ps

module Picker #(
    parameter int ENTRY_NUM = 8,
    parameter int GRANT_NUM = 1
) (
    input  logic [ENTRY_NUM-1:0] request,
    output logic [ENTRY_NUM-1:0] grant,
    output logic [GRANT_NUM-1:0] granted,
    output logic [$clog2(ENTRY_NUM)-1:0] grantPtr [GRANT_NUM]
);

    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM);

    // Requests not yet taken by an earlier grant
    logic [ENTRY_NUM-1:0] remaining;

    always_comb begin
        remaining = request;
        grant = '0;
        for (int k = 0; k < GRANT_NUM; k++) begin
            granted[k] = 1'b0;
            grantPtr[k] = '0;
            // Scan downward so the lowest set bit is kept
            for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
                if (remaining[i]) begin
                    granted[k] = 1'b1;
                    grantPtr[k] = INDEX_WIDTH'(i);
                end
            end
            if (granted[k]) begin
                remaining[grantPtr[k]] = 1'b0;
                grant[grantPtr[k]] = 1'b1;
            end
        end
    end

    // Grant stays inside request and within the grant count
    always_comb begin
        assert (((grant & ~request) == '0) && ($countones(grant) <= GRANT_NUM))
        else $error("Picker grant outside request or over GRANT_NUM");
    end

endmodule : Picker

// File: scheduler/SelectLogic.sv
// ################################################
// Select stage. Builds integer and memory request
// vectors from ready entries, picks per class and
// gathers the winners into issue-port order.
// ################################################

`timescale 1ns/10ps

module SelectLogic #(
    parameter int ENTRY_NUM = 8
) (
    input  SchedulerTypes::IssueQueueEntry entry [ENTRY_NUM],
    output logic [ENTRY_NUM-1:0] grantVector,
    output SchedulerTypes::IssueSlot issueSlot [BasicTypes::ISSUE_WIDTH]
);

    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM);
    localparam int INT_WIDTH = BasicTypes::INT_ISSUE_WIDTH;
    localparam int MEM_WIDTH = BasicTypes::MEM_ISSUE_WIDTH;

    logic [ENTRY_NUM-1:0] intRequest;
    logic [ENTRY_NUM-1:0] memRequest;
    logic [ENTRY_NUM-1:0] intGrant;
    logic [ENTRY_NUM-1:0] memGrant;
    logic [INT_WIDTH-1:0] intGranted;
    logic [MEM_WIDTH-1:0] memGranted;
    logic [INDEX_WIDTH-1:0] intPtr [INT_WIDTH];
    logic [INDEX_WIDTH-1:0] memPtr [MEM_WIDTH];

    Picker #(.ENTRY_NUM(ENTRY_NUM), .GRANT_NUM(INT_WIDTH)) intPicker (
        .request(intRequest),
        .grant(intGrant),
        .granted(intGranted),
        .grantPtr(intPtr)
    );

    Picker #(.ENTRY_NUM(ENTRY_NUM), .GRANT_NUM(MEM_WIDTH)) memPicker (
        .request(memRequest),
        .grant(memGrant),
        .granted(memGranted),
        .grantPtr(memPtr)
    );

    // An entry may request once every source is ready
    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            intRequest[i] = entry[i].valid && (&entry[i].srcReady) &&
                            (entry[i].opClass == SchedulerTypes::OP_INT);
            memRequest[i] = entry[i].valid && (&entry[i].srcReady) &&
                            (entry[i].opClass == SchedulerTypes::OP_MEM);
        end
    end

    assign grantVector = intGrant | memGrant;

    // Integer ports first, memory ports after them
    always_comb begin
        for (int k = 0; k < INT_WIDTH; k++) begin
            issueSlot[k].valid = intGranted[k];
            issueSlot[k].dstTag = entry[intPtr[k]].dstTag;
            issueSlot[k].payload = entry[intPtr[k]].payload;
        end
        for (int k = 0; k < MEM_WIDTH; k++) begin
            issueSlot[INT_WIDTH + k].valid = memGranted[k];
            issueSlot[INT_WIDTH + k].dstTag = entry[memPtr[k]].dstTag;
            issueSlot[INT_WIDTH + k].payload = entry[memPtr[k]].payload;
        end
    end

    always_comb begin
        assert ((intGrant & memGrant) == '0)
        else $error("Entry granted by both pickers");
    end

endmodule : SelectLogic

// File: scheduler/WakeupLogic.sv
// ################################################
// Physical-tag ready table. Issue broadcasts mark
// tags ready, a dispatch claim clears its destination
// tag, and dispatch looks up its source tags here.
// ################################################

`timescale 1ns/10ps

module WakeupLogic (
    input  logic clk,
    input  logic reset,
    input  SchedulerTypes::WakeupBroadcast broadcast [BasicTypes::ISSUE_WIDTH],
    input  logic claimValid,
    input  BasicTypes::PhysTagPath claimTag,
    input  BasicTypes::PhysTagPath [BasicTypes::SRC_OPERAND_NUM-1:0] lookupTag,
    output logic [BasicTypes::SRC_OPERAND_NUM-1:0] lookupReady
);

    localparam int PORT_NUM = BasicTypes::ISSUE_WIDTH;
    localparam int SRC_NUM = BasicTypes::SRC_OPERAND_NUM;

    // One bit per physical register, set when its value exists
    logic [BasicTypes::PHYS_REG_NUM-1:0] readyTable;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Architectural state counts as produced
            readyTable <= '1;
        end else begin
            for (int p = 0; p < PORT_NUM; p++) begin
                if (broadcast[p].valid) begin
                    readyTable[broadcast[p].dstTag] <= 1'b1;
                end
            end
            // A new producer takes the tag over
            if (claimValid) begin
                readyTable[claimTag] <= 1'b0;
            end
        end
    end

    // Bypass covers a producer broadcasting in the lookup cycle
    always_comb begin
        for (int s = 0; s < SRC_NUM; s++) begin
            lookupReady[s] = readyTable[lookupTag[s]];
            for (int p = 0; p < PORT_NUM; p++) begin
                if (broadcast[p].valid && (broadcast[p].dstTag == lookupTag[s])) begin
                    lookupReady[s] = 1'b1;
                end
            end
        end
    end

endmodule : WakeupLogic

// File: source/SchedulerTop.sv
// ################################################
// Scheduler top level. Connects queue, ready table
// and select stage and registers the issue ports;
// the registered slots double as wakeup broadcast.
// ################################################

`timescale 1ns/10ps

module SchedulerTop #(
    parameter int ENTRY_NUM = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  SchedulerTypes::DispatchOp datIn,
    output logic ack,
    output SchedulerTypes::IssueSlot issue [BasicTypes::ISSUE_WIDTH]
);

    localparam int PORT_NUM = BasicTypes::ISSUE_WIDTH;

    SchedulerTypes::IssueQueueEntry entry [ENTRY_NUM];
    SchedulerTypes::IssueSlot issueSlot [PORT_NUM];
    SchedulerTypes::WakeupBroadcast broadcast [PORT_NUM];
    logic [ENTRY_NUM-1:0] grantVector;
    logic claimValid;
    BasicTypes::PhysTagPath claimTag;
    BasicTypes::PhysTagPath [BasicTypes::SRC_OPERAND_NUM-1:0] lookupTag;
    logic [BasicTypes::SRC_OPERAND_NUM-1:0] lookupReady;

    IssueQueue #(.ENTRY_NUM(ENTRY_NUM)) issueQueue (
        .clk, .reset, .flush, .cyc, .stb, .we, .datIn, .ack,
        .broadcast, .grantVector, .entry,
        .claimValid, .claimTag, .lookupTag, .lookupReady
    );

    WakeupLogic wakeupLogic (
        .clk, .reset, .broadcast, .claimValid, .claimTag, .lookupTag, .lookupReady
    );

    SelectLogic #(.ENTRY_NUM(ENTRY_NUM)) selectLogic (
        .entry, .grantVector, .issueSlot
    );

    // Flush drops whatever was selected this cycle
    always_ff @(posedge clk) begin
        for (int p = 0; p < PORT_NUM; p++) begin
            if (reset || flush) begin
                issue[p].valid <= 1'b0;
            end else begin
                issue[p].valid <= issueSlot[p].valid;
            end
            issue[p].dstTag <= issueSlot[p].dstTag;
            issue[p].payload <= issueSlot[p].payload;
        end
    end

    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            broadcast[p].valid = issue[p].valid;
            broadcast[p].dstTag = issue[p].dstTag;
        end
    end

endmodule : SchedulerTop

// File: verif/SchedulerTb.sv
// ################################################
// Testbench for the scheduler top level. Dispatches
// a table of ops over Wishbone, mirrors queue and
// ready table in a reference model and checks issue.
// ################################################

`timescale 1ns/10ps

module SchedulerTb;

    localparam int ROW_NUM = 24;
    localparam int PORT_NUM = BasicTypes::ISSUE_WIDTH;
    localparam int CYCLE_LIMIT = 40 * ROW_NUM + 200;

    logic clk;
    logic reset;
    logic flush;
    logic cyc;
    logic stb;
    logic we;
    logic ack;
    SchedulerTypes::DispatchOp datIn;
    SchedulerTypes::IssueSlot issue [PORT_NUM];

    // Stimulus table
    SchedulerTypes::DispatchOp opTable [ROW_NUM];
    logic flushBefore [ROW_NUM];
    logic stallFlush [ROW_NUM];

    // Reference model state per row
    logic acked [ROW_NUM];
    logic issued [ROW_NUM];
    logic flushed [ROW_NUM];
    logic exact [ROW_NUM];
    int ackCycle [ROW_NUM];
    logic srcReady [ROW_NUM][2];
    int readyCycle [ROW_NUM][2];
    logic [BasicTypes::PHYS_REG_NUM-1:0] tagReady;

    int cycle;
    int curRow;
    logic lastAck;
    logic [31:0] lfsr;

    SchedulerTop #(.ENTRY_NUM(8)) DUT (
        .clk, .reset, .flush, .cyc, .stb, .we, .datIn, .ack, .issue
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        stepLfsr = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic SchedulerTypes::DispatchOp makeOp(
        input SchedulerTypes::OpClass cls, input int dst,
        input logic [1:0] sv, input int s0, input int s1, input int row);
        SchedulerTypes::DispatchOp op;
        op.opClass = cls;
        op.dstTag = BasicTypes::PhysTagPath'(dst);
        op.srcValid = sv;
        op.srcTag[0] = BasicTypes::PhysTagPath'(s0);
        op.srcTag[1] = BasicTypes::PhysTagPath'(s1);
        op.payload = BasicTypes::PayloadPath'(16'hA000 + row);
        return op;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)",
                     $time, msg, actual, expected);
            $display("Done: errors found");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic loadTable();
        for (int r = 0; r < ROW_NUM; r++) begin
            flushBefore[r] = 1'b0;
            stallFlush[r] = 1'b0;
        end
        opTable[0] = makeOp(SchedulerTypes::OP_INT, 1, 2'b00, 0, 0, 0);
        opTable[1] = makeOp(SchedulerTypes::OP_MEM, 2, 2'b01, 1, 0, 1);
        opTable[2] = makeOp(SchedulerTypes::OP_INT, 3, 2'b11, 1, 2, 2);
        opTable[3] = makeOp(SchedulerTypes::OP_INT, 4, 2'b00, 0, 0, 3);
        opTable[4] = makeOp(SchedulerTypes::OP_INT, 5, 2'b00, 0, 0, 4);
        opTable[5] = makeOp(SchedulerTypes::OP_MEM, 6, 2'b01, 4, 0, 5);
        opTable[6] = makeOp(SchedulerTypes::OP_INT, 7, 2'b11, 5, 6, 6);
        opTable[7] = makeOp(SchedulerTypes::OP_MEM, 8, 2'b00, 0, 0, 7);
        opTable[8] = makeOp(SchedulerTypes::OP_INT, 9, 2'b10, 0, 7, 8);
        // Flushed before it can issue, so tag 20 is never produced
        opTable[9] = makeOp(SchedulerTypes::OP_INT, 20, 2'b00, 0, 0, 9);
        for (int r = 10; r < 18; r++) begin
            opTable[r] = makeOp((r % 3 == 0) ? SchedulerTypes::OP_MEM : SchedulerTypes::OP_INT,
                                r + 11, 2'b01, 20, 0, r);
        end
        flushBefore[10] = 1'b1;
        opTable[18] = makeOp(SchedulerTypes::OP_INT, 29, 2'b00, 0, 0, 18);
        stallFlush[18] = 1'b1;
        opTable[19] = makeOp(SchedulerTypes::OP_INT, 10, 2'b01, 29, 0, 19);
        opTable[20] = makeOp(SchedulerTypes::OP_MEM, 11, 2'b01, 10, 0, 20);
        opTable[21] = makeOp(SchedulerTypes::OP_INT, 12, 2'b10, 0, 3, 21);
        opTable[22] = makeOp(SchedulerTypes::OP_INT, 1, 2'b11, 11, 12, 22);
        opTable[23] = makeOp(SchedulerTypes::OP_MEM, 13, 2'b00, 0, 0, 23);
    endtask

    // Reference model update for one cycle, sampled at the falling edge
    task automatic observe();
        int row;
        logic busy;
        cycle++;
        if (cycle > CYCLE_LIMIT) begin
            $display("Timeout: the run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $fatal(1, "Timeout");
        end
        for (int p = 0; p < PORT_NUM; p++) begin
            if (issue[p].valid) begin
                row = -1;
                for (int r = 0; r < ROW_NUM; r++) begin
                    if (opTable[r].payload == issue[p].payload) row = r;
                end
                checkValue(row >= 0, 1, "issue carries a known payload");
                checkValue(acked[row] && !issued[row] && !flushed[row], 1,
                           "issued op is pending in the model");
                checkValue(opTable[row].opClass, (p < BasicTypes::INT_ISSUE_WIDTH) ?
                           SchedulerTypes::OP_INT : SchedulerTypes::OP_MEM, "issue port class");
                checkValue(issue[p].dstTag, opTable[row].dstTag, "issue dstTag");
                for (int s = 0; s < 2; s++) begin
                    checkValue(srcReady[row][s] && (readyCycle[row][s] < cycle), 1,
                               "source ready before issue");
                end
                if (exact[row]) begin
                    checkValue(cycle, ackCycle[row] + 2, "issue one cycle after ack");
                end
                issued[row] = 1'b1;
            end
        end
        // Wakeup from this cycle's broadcast
        for (int p = 0; p < PORT_NUM; p++) begin
            if (issue[p].valid) begin
                tagReady[issue[p].dstTag] = 1'b1;
                for (int r = 0; r < ROW_NUM; r++) begin
                    for (int s = 0; s < 2; s++) begin
                        if (acked[r] && !issued[r] && !srcReady[r][s] &&
                            opTable[r].srcTag[s] == issue[p].dstTag) begin
                            srcReady[r][s] = 1'b1;
                            readyCycle[r][s] = cycle;
                        end
                    end
                end
            end
        end
        if (flush) begin
            for (int r = 0; r < ROW_NUM; r++) begin
                if (acked[r] && !issued[r]) flushed[r] = 1'b1;
            end
        end
        lastAck = ack;
        if (ack) begin
            busy = 1'b0;
            for (int r = 0; r < ROW_NUM; r++) begin
                if (acked[r] && !issued[r] && !flushed[r] &&
                    opTable[r].opClass == opTable[curRow].opClass) busy = 1'b1;
            end
            for (int s = 0; s < 2; s++) begin
                srcReady[curRow][s] = !opTable[curRow].srcValid[s] ||
                                      tagReady[opTable[curRow].srcTag[s]];
                readyCycle[curRow][s] = cycle;
            end
            tagReady[opTable[curRow].dstTag] = 1'b0;
            acked[curRow] = 1'b1;
            ackCycle[curRow] = cycle;
            exact[curRow] = !busy && srcReady[curRow][0] && srcReady[curRow][1];
        end
    endtask

    // Observe one cycle, then move to 1 ns after the next rising edge
    task automatic tick();
        @(negedge clk);
        observe();
        @(posedge clk);
        #1;
    endtask

    task automatic dispatchRow(input int r);
        int waited;
        if (flushBefore[r]) begin
            flush = 1'b1;
            tick();
            flush = 1'b0;
        end
        if (lfsr[0]) tick();
        lfsr = stepLfsr(lfsr);
        curRow = r;
        datIn = opTable[r];
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        waited = 0;
        lastAck = 1'b0;
        while (!lastAck) begin
            if (stallFlush[r] && waited == 20) begin
                flush = 1'b1;
            end
            tick();
            flush = 1'b0;
            if (stallFlush[r] && waited < 20) begin
                checkValue(lastAck, 0, "no ack while the queue is full");
            end
            waited++;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    initial begin
        logic pending;
        reset = 1'b1;
        flush = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        datIn = '0;
        cycle = 0;
        curRow = 0;
        lfsr = 32'h1d67b5e7;
        tagReady = '1;
        loadTable();
        for (int r = 0; r < ROW_NUM; r++) begin
            acked[r] = 1'b0;
            issued[r] = 1'b0;
            flushed[r] = 1'b0;
            exact[r] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        // Quiet outputs before the first request
        repeat (3) begin
            @(negedge clk);
            checkValue(ack, 0, "ack low after reset");
            for (int p = 0; p < PORT_NUM; p++) begin
                checkValue(issue[p].valid, 0, "issue valid low after reset");
            end
        end
        @(posedge clk);
        #1;
        for (int r = 0; r < ROW_NUM; r++) begin
            dispatchRow(r);
        end
        pending = 1'b1;
        while (pending) begin
            tick();
            pending = 1'b0;
            for (int r = 0; r < ROW_NUM; r++) begin
                if (acked[r] && !issued[r] && !flushed[r]) pending = 1'b1;
            end
        end
        repeat (5) tick();
        for (int r = 0; r < ROW_NUM; r++) begin
            checkValue(acked[r], 1, "every row was acked");
            checkValue(issued[r] != flushed[r], 1, "issued exactly when not flushed");
        end
        $display("Done: no errors");
        $finish;
    end

endmodule : SchedulerTb
